// File: Makefile
TOP = knight_drive_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f tb.f --top-module $(TOP)

# The run passes only if the pass line shows up in the output.
sim:
	verilator --binary --timing --assert -f tb.f --top-module $(TOP)
	./obj_dir/V$(TOP) | awk '{ print } /^>>> PASS$$/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf obj_dir

// File: common/drive_pkg.sv
// Drive types for the forward command, wheel speeds and PWM counts.
`include "nav_config.svh"

package drive_pkg;

  ////////////////////////////////////////
  // Speed commands
  ////////////////////////////////////////
  typedef logic [9:0] frwrd_t;         // Forward speed, never negative.
  typedef logic signed [10:0] spd_t;   // Wheel speed, sign gives direction.

  ////////////////////////////////////////
  // PWM
  ////////////////////////////////////////
  // Duty count, compared against the free-running counter.
  typedef logic [`PWM_W-1:0] duty_t;

endpackage

// File: common/nav_config.svh
// Compile-time gains and widths for the heading-hold PID and the motor drive.
`ifndef NAV_CONFIG_SVH
`define NAV_CONFIG_SVH

////////////////////////////////////////
// PID gains
////////////////////////////////////////
`define P_COEFF 16 // Proportional gain, the product is halved afterwards.
`define D_COEFF 7  // Derivative gain on the clamped three-back difference.

////////////////////////////////////////
// Datapath widths
////////////////////////////////////////
// Integrator width. Its top 9 bits form the I term.
`define INT_W 15

// PWM counter width. One period is 2**PWM_W cycles.
`define PWM_W 10

`endif

// File: common/nav_pkg.sv
// Navigation types for heading angles, heading errors and PID terms.
`include "nav_config.svh"

package nav_pkg;

  ////////////////////////////////////////
  // Heading side
  ////////////////////////////////////////
  // Unsigned angle, a full turn is 4096 counts.
  typedef logic [11:0] heading_t;

  // Wrapped heading difference, read as two's complement.
  typedef logic signed [11:0] error_t;

  ////////////////////////////////////////
  // PID side
  ////////////////////////////////////////
  // Error clamped to -512..511.
  typedef logic signed [9:0] err_sat_t;

  // Accumulated error. Guarded against overflow in the PID.
  typedef logic signed [`INT_W-1:0] integ_t;

endpackage

// File: hw/heading_err.sv
// Heading error stage that registers the wrapped heading difference per gyro sample.
module heading_err (
  input  logic              clk,          // System clock.
  input  logic              rst_n,        // Asynchronous reset, active low.
  input  logic              hdg_vld,      // New gyro sample this cycle.
  input  nav_pkg::heading_t desired_hdg,  // Commanded heading.
  input  nav_pkg::heading_t actual_hdg,   // Measured heading.
  output nav_pkg::error_t   error,        // Held until the next sample.
  output logic              err_vld       // One-cycle pulse after hdg_vld.
);

  import nav_pkg::*;

  error_t hdg_diff; // Difference before the register.

  ////////////////////////////////////////
  // Wrapped difference
  ////////////////////////////////////////
  // Modulo 4096 falls out of the 12-bit subtract, so 4095 to 0 reads as -1.
  assign hdg_diff = error_t'(desired_hdg - actual_hdg);

  ////////////////////////////////////////
  // Output registers
  ////////////////////////////////////////
  // Error only moves on a strobe.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      error <= '0;
    end else if (hdg_vld) begin
      error <= hdg_diff; // Capture the new sample.
    end
  end

  // Strobe delayed by one cycle to line up with the error.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      err_vld <= 1'b0;
    end else begin
      err_vld <= hdg_vld;
    end
  end

endmodule

// File: hw/knight_drive.sv
// Heading-hold drive top level chaining heading error, PID and motor drive.
module knight_drive (
  input  logic              clk,          // System clock.
  input  logic              rst_n,        // Asynchronous reset, active low.
  input  logic              hdg_vld,      // New gyro sample.
  input  nav_pkg::heading_t desired_hdg,
  input  nav_pkg::heading_t actual_hdg,
  input  logic              moving,       // Level, robot active.
  input  drive_pkg::frwrd_t frwrd,        // Level, forward speed.
  output drive_pkg::spd_t   lft_spd,      // Telemetry.
  output drive_pkg::spd_t   rght_spd,     // Telemetry.
  output logic              lft_pwm,
  output logic              rght_pwm,
  output logic              lft_rev,
  output logic              rght_rev
);

  import nav_pkg::*;

  error_t error;    // Registered heading error.
  logic   err_vld;  // Pulses one cycle after hdg_vld.

  ////////////////////////////////////////
  // Stages
  ////////////////////////////////////////
  heading_err heading_err_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .hdg_vld     (hdg_vld),
    .desired_hdg (desired_hdg),
    .actual_hdg  (actual_hdg),
    .error       (error),
    .err_vld     (err_vld)
  );

  pid pid_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .moving   (moving),
    .err_vld  (err_vld),
    .error    (error),
    .frwrd    (frwrd),
    .lft_spd  (lft_spd),
    .rght_spd (rght_spd)
  );

  mtr_drv mtr_drv_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .lft_spd  (lft_spd),
    .rght_spd (rght_spd),
    .lft_pwm  (lft_pwm),
    .rght_pwm (rght_pwm),
    .lft_rev  (lft_rev),
    .rght_rev (rght_rev)
  );

endmodule

// File: hw/mtr_drv.sv
// Motor drive stage producing a PWM signal and reverse flag for each wheel.
`include "nav_config.svh"

module mtr_drv (
  input  logic            clk,       // System clock.
  input  logic            rst_n,     // Asynchronous reset, active low.
  input  drive_pkg::spd_t lft_spd,   // Signed left speed.
  input  drive_pkg::spd_t rght_spd,  // Signed right speed.
  output logic            lft_pwm,
  output logic            rght_pwm,
  output logic            lft_rev,   // Left wheel turns backwards.
  output logic            rght_rev
);

  import drive_pkg::*;

  localparam duty_t DUTY_MAX = {`PWM_W{1'b1}}; // Full-on duty.

  duty_t pwm_cnt;               // Free-running, one wrap per period.
  duty_t lft_duty, rght_duty;

  // Magnitude of a speed, capped at full duty.
  function automatic duty_t spd_to_duty(input spd_t spd);
    logic [$bits(spd_t)-1:0] mag;
    mag = spd[$bits(spd_t)-1] ? $bits(spd_t)'(-spd) : $bits(spd_t)'(spd);
    return (mag > DUTY_MAX) ? DUTY_MAX : duty_t'(mag); // -1024 lands here.
  endfunction

  ////////////////////////////////////////
  // PWM counter
  ////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pwm_cnt <= '0;
    end else begin
      pwm_cnt <= pwm_cnt + 1'b1; // Wraps every 1024 cycles.
    end
  end

  assign lft_duty  = spd_to_duty(lft_spd);
  assign rght_duty = spd_to_duty(rght_spd);

  ////////////////////////////////////////
  // Registered outputs
  ////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      lft_pwm  <= 1'b0;
      rght_pwm <= 1'b0;
      lft_rev  <= 1'b0;
      rght_rev <= 1'b0;
    end else begin
      lft_pwm  <= (pwm_cnt < lft_duty);   // High for lft_duty counts.
      rght_pwm <= (pwm_cnt < rght_duty);
      lft_rev  <= lft_spd[$bits(spd_t)-1];  // Sign bit.
      rght_rev <= rght_spd[$bits(spd_t)-1];
    end
  end

endmodule

// File: pid/pid.sv
// PID controller that turns the heading error into left and right wheel speeds.
`include "nav_config.svh"

module pid (
  input  logic              clk,       // System clock.
  input  logic              rst_n,     // Asynchronous reset, active low.
  input  logic              moving,    // Robot active, PID enabled.
  input  logic              err_vld,   // New error this cycle.
  input  nav_pkg::error_t   error,     // Signed heading error.
  input  drive_pkg::frwrd_t frwrd,     // Forward speed the correction rides on.
  output drive_pkg::spd_t   lft_spd,   // Left wheel speed.
  output drive_pkg::spd_t   rght_spd   // Right wheel speed.
);

  import nav_pkg::*;
  import drive_pkg::*;

  localparam int P_GAIN = `P_COEFF;
  localparam int D_GAIN = `D_COEFF;

  err_sat_t           err_sat;          // Clamped error.
  logic signed [13:0] p_prod;           // err_sat times the P gain.
  logic signed [13:0] p_term;
  integ_t             err_ext;          // err_sat widened to the integrator.
  integ_t             integ_sum;
  logic               integ_ov;         // Sum would wrap.
  integ_t             integrator;
  integ_t             integrator_nxt;
  logic signed [8:0]  i_term;
  err_sat_t           hist_1, hist_2, hist_3; // Last three err_sat values.
  logic signed [10:0] d_diff;           // One bit wider so 511 - (-512) fits.
  logic signed [7:0]  d_sat;
  logic signed [13:0] d_term;
  logic signed [13:0] pid_sum;
  spd_t               pid_shft;         // Sum after the arithmetic shift by 3.
  spd_t               raw_lft, raw_rght;

  ////////////////////////////////////////
  // P term
  ////////////////////////////////////////
  assign err_sat = (error > 12'sd511)  ? 10'sd511  :
                   (error < -12'sd512) ? -10'sd512 :
                   err_sat_t'(error);

  assign p_prod = 14'(err_sat) * 14'(P_GAIN);
  assign p_term = p_prod >>> 1; // Halve.

  ////////////////////////////////////////
  // I term
  ////////////////////////////////////////
  assign err_ext   = integ_t'(err_sat); // Sign extend.
  assign integ_sum = integrator + err_ext;

  // Overflow only when both operands agree in sign and the sum does not.
  assign integ_ov = (err_ext[`INT_W-1] == integrator[`INT_W-1]) &&
                    (integ_sum[`INT_W-1] != integrator[`INT_W-1]);

  always_comb begin
    if (!moving) begin
      integrator_nxt = '0;          // Idle clears it.
    end else if (err_vld && !integ_ov) begin
      integrator_nxt = integ_sum;
    end else begin
      integrator_nxt = integrator;  // Hold, either no strobe or overflow.
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      integrator <= '0;
    end else begin
      integrator <= integrator_nxt;
    end
  end

  assign i_term = integrator[`INT_W-1 -: 9]; // Top 9 bits.

  ////////////////////////////////////////
  // D term
  ////////////////////////////////////////
  // Three-deep history, shifts once per strobe.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      hist_1 <= '0;
      hist_2 <= '0;
      hist_3 <= '0;
    end else if (err_vld) begin
      hist_1 <= err_sat;
      hist_2 <= hist_1;
      hist_3 <= hist_2;
    end
  end

  assign d_diff = 11'(err_sat) - 11'(hist_3);

  assign d_sat = (d_diff > 11'sd127)  ? 8'sd127  :
                 (d_diff < -11'sd128) ? -8'sd128 :
                 d_diff[7:0];

  assign d_term = 14'(d_sat) * 14'(D_GAIN);

  ////////////////////////////////////////
  // Sum and wheel speeds
  ////////////////////////////////////////
  assign pid_sum  = p_term + 14'(i_term) + d_term;
  assign pid_shft = pid_sum[13:3];          // Arithmetic shift right by 3.

  assign raw_lft  = spd_t'({1'b0, frwrd}) + pid_shft;
  assign raw_rght = spd_t'({1'b0, frwrd}) - pid_shft;

  // A positive correction cannot legitimately drive the left wheel negative.
  assign lft_spd  = !moving                       ? '0           :
                    (!pid_sum[13] && raw_lft[10]) ? 11'sd1023    :
                    raw_lft;

  // Same for the right wheel with a negative correction.
  assign rght_spd = !moving                       ? '0           :
                    (pid_sum[13] && raw_rght[10]) ? 11'sd1023    :
                    raw_rght;

endmodule

// File: tb.f
+incdir+common
common/nav_pkg.sv
common/drive_pkg.sv
hw/heading_err.sv
pid/pid.sv
hw/mtr_drv.sv
hw/knight_drive.sv
verif/knight_drive_sva.sv
verif/knight_drive_tb.sv

// File: verif/knight_drive_sva.sv
// Concurrent checks on the drive top level for the error strobe, idle speeds and reverse flags.
module knight_drive_sva (
  input logic            clk,
  input logic            rst_n,
  input logic            moving,
  input logic            err_vld,   // Internal strobe between heading_err and pid.
  input drive_pkg::spd_t lft_spd,
  input drive_pkg::spd_t rght_spd,
  input logic            lft_rev,
  input logic            rght_rev
);

  import drive_pkg::*;

  localparam int SGN = $bits(spd_t) - 1; // Sign bit of a speed.

  ////////////////////////////////////////
  // Strobe and idle
  ////////////////////////////////////////
  err_vld_single : assert property (@(posedge clk) disable iff (!rst_n)
    err_vld |=> !err_vld)
    else $error("err_vld stayed high for two cycles");

  idle_zero : assert property (@(posedge clk) disable iff (!rst_n)
    !moving |-> (lft_spd == '0 && rght_spd == '0))
    else $error("Wheel speeds not zero while moving is low");

  ////////////////////////////////////////
  // Reverse flags lag the speed sign by one cycle
  ////////////////////////////////////////
  lft_rev_sign : assert property (@(posedge clk) disable iff (!rst_n)
    lft_rev == $past(lft_spd[SGN]))
    else $error("lft_rev does not follow the sign of lft_spd");

  rght_rev_sign : assert property (@(posedge clk) disable iff (!rst_n)
    rght_rev == $past(rght_spd[SGN]))
    else $error("rght_rev does not follow the sign of rght_spd");

endmodule

bind knight_drive knight_drive_sva knight_drive_sva_i (
  .clk (clk), .rst_n (rst_n), .moving (moving), .err_vld (err_vld),
  .lft_spd (lft_spd), .rght_spd (rght_spd), .lft_rev (lft_rev), .rght_rev (rght_rev)
);

// File: verif/knight_drive_tb.sv
// Testbench for the heading-hold drive with LFSR stimulus and a reference model of the PID.
`include "nav_config.svh"

module knight_drive_tb;

  import nav_pkg::*;
  import drive_pkg::*;

  logic     clk = 1'b0;
  logic     rst_n, hdg_vld, moving;
  heading_t desired_hdg, actual_hdg;
  frwrd_t   frwrd;
  spd_t     lft_spd, rght_spd;
  logic     lft_pwm, rght_pwm, lft_rev, rght_rev;

  logic [31:0] lfsr_state = 32'h8b5d30f3; // Fixed seed.
  int   m_esat, m_integ, m_frwrd;         // Model state.
  int   m_h1, m_h2, m_h3;                 // Model err_sat history with m_h3 the oldest.
  logic m_moving;
  int   exp_lft, exp_rght;                // Model speeds.

  knight_drive knight_drive_i (
    .clk (clk), .rst_n (rst_n), .hdg_vld (hdg_vld), .desired_hdg (desired_hdg),
    .actual_hdg (actual_hdg), .moving (moving), .frwrd (frwrd), .lft_spd (lft_spd),
    .rght_spd (rght_spd), .lft_pwm (lft_pwm), .rght_pwm (rght_pwm),
    .lft_rev (lft_rev), .rght_rev (rght_rev)
  );

  always #10 clk = ~clk; // Period 20.

  ////////////////////////////////////////
  // Random bits
  ////////////////////////////////////////
  function automatic logic lfsr_bit();
    logic out;
    out = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (out) lfsr_state = lfsr_state ^ 32'hD000_0001; // Galois taps 32,31,29,1.
    return out;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) v = {v[30:0], lfsr_bit()}; // One step per bit.
    return v;
  endfunction

  ////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////
  function automatic int clamp(input int v, input int lo, input int hi);
    return (v < lo) ? lo : (v > hi) ? hi : v;
  endfunction

  // Heading difference modulo 4096, read as signed.
  function automatic int wrap_error(input heading_t d, input heading_t a);
    int e;
    e = (int'(d) - int'(a)) & 4095;
    return (e >= 2048) ? e - 4096 : e;
  endfunction

  function automatic void predict();
    int p, i, d, s;
    p = (m_esat * `P_COEFF) >>> 1;
    i = m_integ >>> (`INT_W - 9);                         // Top 9 bits.
    d = clamp(m_esat - m_h3, -128, 127) * `D_COEFF;
    s = (p + i + d) >>> 3;
    exp_lft  = m_moving ? clamp(m_frwrd + s, -2048, 1023) : 0; // Overshoot pins at 1023.
    exp_rght = m_moving ? clamp(m_frwrd - s, -2048, 1023) : 0;
  endfunction

  // Effect of one err_vld cycle on the integrator and history.
  function automatic void commit();
    int sum;
    sum = m_integ + m_esat;
    if (!m_moving) m_integ = 0;
    else if (sum >= -(1 << (`INT_W - 1)) && sum < (1 << (`INT_W - 1))) m_integ = sum;
    m_h3 = m_h2;
    m_h2 = m_h1;
    m_h1 = m_esat;
  endfunction

  function automatic int duty_of(input int spd);
    return clamp((spd < 0) ? -spd : spd, 0, 1023);
  endfunction

  ////////////////////////////////////////
  // Checks
  ////////////////////////////////////////
  task automatic fail_run();
    $display(">>> FAIL");
    $fatal(1, "Stopped at the first error.");
  endtask

  task automatic check_value(input string name, input int exp, input int act);
    assert (exp == act) else begin
      $display("Fail at %0t: %s expected %0d, got %0d", $time, name, exp, act);
      fail_run();
    end
  endtask

  task automatic check_speeds();
    predict();
    check_value("lft_spd", exp_lft, int'(lft_spd));
    check_value("rght_spd", exp_rght, int'(rght_spd));
  endtask

  // err_vld should show up on the first negedge after the strobe edge.
  task automatic wait_err_vld();
    int cycles;
    cycles = 0;
    do begin
      @(negedge clk);
      cycles++;
      if (cycles > 8) begin
        $display("Timeout: err_vld never followed hdg_vld.");
        fail_run();
      end
    end while (knight_drive_i.err_vld !== 1'b1);
    check_value("err_vld delay", 1, cycles);
  endtask

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////
  task automatic run_sample(input heading_t d, input heading_t a, input frwrd_t f);
    @(posedge clk);
    hdg_vld     <= 1'b1;
    desired_hdg <= d;
    actual_hdg  <= a;
    frwrd       <= f;
    @(posedge clk);
    hdg_vld <= 1'b0;
    m_frwrd = int'(f);
    m_esat  = clamp(wrap_error(d, a), -512, 511);
    wait_err_vld();
    check_speeds(); // New error, old integrator and history.
    commit();
    @(negedge clk);
    check_speeds(); // I and D of this sample now in.
  endtask

  task automatic set_moving(input logic mv);
    @(posedge clk);
    moving  <= mv;
    m_moving = mv;
    if (!mv) m_integ = 0; // Cleared on any idle cycle.
    @(negedge clk);
    check_speeds();
  endtask

  task automatic pick_pair(output heading_t d, output heading_t a);
    logic [1:0] mode;
    mode = 2'(rand_bits(2));
    d    = heading_t'(rand_bits(12));
    a    = heading_t'(rand_bits(12));
    if (mode == 2'd1) begin                         // Across the 0/4095 wrap.
      d = heading_t'(rand_bits(6));
      a = heading_t'(12'd4095 - heading_t'(rand_bits(6)));
    end else if (mode == 2'd2) begin                // Small error either way.
      a = heading_t'(d + heading_t'(rand_bits(8)) - 12'd128);
    end
    if (rand_bits(1) == 32'd1) {d, a} = {a, d};
  endtask

  // Counts PWM highs over one full 1024-cycle period with the speeds held.
  task automatic check_pwm();
    int lft_high, rght_high;
    lft_high  = 0;
    rght_high = 0;
    predict();
    @(negedge clk); // Registered outputs catch up.
    check_value("lft_rev", (exp_lft < 0) ? 1 : 0, int'(lft_rev));
    check_value("rght_rev", (exp_rght < 0) ? 1 : 0, int'(rght_rev));
    for (int k = 0; k < 1024; k++) begin
      @(negedge clk);
      if (lft_pwm) lft_high++;
      if (rght_pwm) rght_high++;
    end
    check_value("lft_pwm duty", duty_of(exp_lft), lft_high);
    check_value("rght_pwm duty", duty_of(exp_rght), rght_high);
  endtask

  ////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////
  initial begin
    heading_t d, a, base, off;
    logic     sgn;
    int       len;
    rst_n = 1'b0;
    hdg_vld = 1'b0;
    desired_hdg = '0;
    actual_hdg = '0;
    moving = 1'b0;
    frwrd = '0;
    {m_esat, m_integ, m_frwrd, m_h1, m_h2, m_h3} = '0;
    m_moving = 1'b0;
    for (int k = 0; k < 5; k++) @(posedge clk); // Reset for 5 cycles.
    rst_n <= 1'b1;
    @(negedge clk);
    check_value("lft_pwm", 0, int'(lft_pwm));
    check_value("rght_pwm", 0, int'(rght_pwm));
    check_value("lft_rev", 0, int'(lft_rev));
    check_value("rght_rev", 0, int'(rght_rev));
    check_speeds();
    set_moving(1'b1);
    for (int k = 0; k < 150; k++) begin // Wrap, saturation and mixed errors.
      pick_pair(d, a);
      run_sample(d, a, frwrd_t'(rand_bits(10)));
    end
    for (int r = 0; r < 4; r++) begin   // Same-sign runs drive the overflow hold.
      sgn  = rand_bits(1) == 32'd1;
      base = heading_t'(rand_bits(12));
      len  = 36 + int'(rand_bits(4));
      for (int j = 0; j < len; j++) begin
        off = heading_t'(600 + rand_bits(9));
        if (sgn) run_sample(heading_t'(base + off), base, frwrd_t'(896 + rand_bits(7)));
        else run_sample(base, heading_t'(base + off), frwrd_t'(896 + rand_bits(7)));
      end
    end
    set_moving(1'b0);                   // A single idle cycle empties the integrator.
    set_moving(1'b1);
    set_moving(1'b0);                   // Idle clears the integrator while the history shifts.
    run_sample(12'd300, 12'd0, 10'd500);
    set_moving(1'b1);
    for (int k = 0; k < 20; k++) begin
      pick_pair(d, a);
      run_sample(d, a, frwrd_t'(rand_bits(10)));
    end
    run_sample(12'd600, 12'd0, 10'd40); // Right wheel backwards.
    check_pwm();
    run_sample(12'd4000, 12'd100, 10'd700);
    check_pwm();
    $display(">>> PASS");
    $finish;
  end

endmodule
